// File: sim/piano_input.txt
// Columns: action key mode led digit (hex). Actions 0 idle, 1 nav tap, 2 note hold,
// 3 note release, 4 nav glitch, 5 note tap. Nav keys: 5 center 4 up 3 down 2 left 1 right 0 esc
0 0 0 00 0
4 5 0 00 0
1 5 1 00 0
1 0 0 00 0
1 5 1 00 0
2 3 1 00 0
3 3 1 00 0
// Cursor walk on the choose page
1 4 1 00 0
1 5 9 00 0
1 0 1 00 0
1 4 1 00 0
1 5 4 00 1
1 0 1 00 0
1 3 1 00 0
1 1 1 00 0
1 5 a 00 0
1 0 1 00 0
1 3 1 00 0
// Song list paging
1 5 3 00 1
1 3 3 00 2
1 4 3 00 1
1 4 3 00 4
1 2 3 00 8
1 3 3 00 5
4 3 3 00 5
1 5 6 00 5
2 2 6 04 5
3 2 6 00 5
1 0 3 00 5
1 0 1 00 0
// Free mode with identity map
1 2 1 00 0
1 5 2 00 0
2 1 2 02 0
3 1 2 00 0
1 0 1 00 0
// Teach a reversed map
1 4 1 00 0
1 5 9 00 0
5 7 9 00 0
5 6 9 00 0
5 5 9 00 0
5 4 9 00 0
5 3 9 00 0
5 2 9 00 0
5 1 9 00 0
5 0 1 00 0
1 3 1 00 0
1 5 2 00 0
2 1 2 40 0
3 1 2 00 0
2 7 2 01 0
3 7 2 00 0
1 0 1 00 0
1 0 0 00 0

// File: compile.f
+incdir+source
source/piano_pkg.sv
source/key_debouncer.sv
source/key_remap.sv
source/mode_fsm.sv
source/song_selector.sv
source/tub_text.sv
source/piano_top.sv
sim/tb_piano.sv

// File: Bender.yml
package:
  name: piano_front_end

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/piano_pkg.sv
      - source/key_debouncer.sv
      - source/key_remap.sv
      - source/mode_fsm.sv
      - source/song_selector.sv
      - source/tub_text.sv
      - source/piano_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_piano.sv

// File: sim/tb_piano.sv
`timescale 1ns/1ps
`default_nettype none
`include "piano_settings.svh"

module tb_piano
	import piano_pkg::*;
();

	localparam int max_steps = 64;
	localparam int fields = 5;
	localparam int bounce_max = 3;
	localparam int hold_cycles = 3 * `KEY_STABLE_CYCLES;
	localparam int gap_cycles = 3 * `KEY_STABLE_CYCLES;
	localparam int step_cycles = 2 * (bounce_max + 1) + hold_cycles + gap_cycles + 1;
	localparam int margin_cycles = 50;

	logic       slow_clk;
	logic       rst_n;
	nav_keys_t  nav_raw;
	note_vec_t  note_raw_n;
	mode_t      mode;
	note_vec_t  led;
	tub_frame_t tub_frame;

	logic [7:0] stim_mem [max_steps*fields];
	int         n_steps;
	logic       stim_loaded;

	piano_top u_dut (
		.slow_clk   (slow_clk),
		.rst_n      (rst_n),
		.nav_raw    (nav_raw),
		.note_raw_n (note_raw_n),
		.mode       (mode),
		.led        (led),
		.tub_frame  (tub_frame)
	);

	initial begin
		slow_clk = 1'b0;
		forever #20 slow_clk = ~slow_clk;
	end

	task automatic finish_failed(input string why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	// Note buttons are active low on the board
	task automatic drive_key(input logic is_note, input int key, input logic pressed);
		if (is_note) begin
			note_raw_n[key] <= ~pressed;
		end else begin
			nav_raw[key] <= pressed;
		end
	endtask

	// A few random chatter cycles, then the final level
	task automatic bounce_to(input logic is_note, input int key, input logic pressed);
		int n;
		n = 1 + ($urandom % bounce_max);
		repeat (n) begin
			@(posedge slow_clk);
			drive_key(is_note, key, logic'($urandom % 2));
		end
		@(posedge slow_clk);
		drive_key(is_note, key, pressed);
	endtask

	// Pressed one cycle short of the debounce length
	task automatic short_glitch(input logic is_note, input int key);
		@(posedge slow_clk);
		drive_key(is_note, key, 1'b1);
		repeat (`KEY_STABLE_CYCLES - 1) @(posedge slow_clk);
		drive_key(is_note, key, 1'b0);
	endtask

	function automatic glyph_t digit_glyph(input int digit);
		case (digit)
			1:       return `GLYPH_1;
			2:       return `GLYPH_2;
			3:       return `GLYPH_3;
			4:       return `GLYPH_4;
			5:       return `GLYPH_5;
			6:       return `GLYPH_6;
			7:       return `GLYPH_7;
			8:       return `GLYPH_8;
			default: return `GLYPH_BLANK;
		endcase
	endfunction

	function automatic tub_frame_t expected_frame(input mode_t m, input int digit);
		tub_frame_t f;
		f = {8{`GLYPH_BLANK}};
		case (m)
			mode_welcome: f = {`GLYPH_H, `GLYPH_E, `GLYPH_L, `GLYPH_L,
				`GLYPH_O, `GLYPH_BLANK, `GLYPH_BLANK, `GLYPH_BLANK};
			mode_choose: f = {`GLYPH_C, `GLYPH_H, `GLYPH_O, `GLYPH_O,
				`GLYPH_S, `GLYPH_E, `GLYPH_BLANK, `GLYPH_BLANK};
			mode_song_play, mode_song_learn, mode_song_game,
			mode_play, mode_learn, mode_game: f = {`GLYPH_S, `GLYPH_O, `GLYPH_N, `GLYPH_G,
				`GLYPH_BLANK, `GLYPH_BLANK, `GLYPH_0, digit_glyph(digit)};
			default: f = {8{`GLYPH_BLANK}};
		endcase
		return f;
	endfunction

	function automatic string action_name(input logic [7:0] act);
		case (act)
			8'h0:    return "idle";
			8'h1:    return "nav tap";
			8'h2:    return "note hold";
			8'h3:    return "note release";
			8'h4:    return "nav glitch";
			8'h5:    return "note tap";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_outputs(input string name, input mode_t exp_mode,
		input note_vec_t exp_led, input int exp_digit);
		tub_frame_t exp_frame;
		exp_frame = expected_frame(exp_mode, exp_digit);
		assert (mode === exp_mode) else begin
			$display("FAIL %s: mode expected %0d actual %0d", name, exp_mode, mode);
			finish_failed("mode mismatch");
		end
		assert (led === exp_led) else begin
			$display("FAIL %s: led expected %02h actual %02h", name, exp_led, led);
			finish_failed("led mismatch");
		end
		assert (tub_frame === exp_frame) else begin
			$display("FAIL %s: frame expected %016h actual %016h", name, exp_frame, tub_frame);
			finish_failed("frame mismatch");
		end
	endtask

	task automatic run_step(input int s);
		logic [7:0] act;
		int         key;
		mode_t      exp_mode;
		note_vec_t  exp_led;
		int         exp_digit;
		string      name;
		act = stim_mem[s*fields];
		key = int'(stim_mem[s*fields+1]);
		exp_mode = mode_t'(stim_mem[s*fields+2][3:0]);
		exp_led = stim_mem[s*fields+3];
		exp_digit = int'(stim_mem[s*fields+4]);
		name = $sformatf("step %0d %s", s + 1, action_name(act));
		case (act)
			8'h0: repeat (gap_cycles) @(posedge slow_clk);
			8'h1, 8'h5: begin
				bounce_to(act == 8'h5, key, 1'b1);
				repeat (hold_cycles) @(posedge slow_clk);
				bounce_to(act == 8'h5, key, 1'b0);
				repeat (gap_cycles) @(posedge slow_clk);
			end
			8'h2: begin
				bounce_to(1'b1, key, 1'b1);
				repeat (hold_cycles + gap_cycles) @(posedge slow_clk);
			end
			8'h3: begin
				bounce_to(1'b1, key, 1'b0);
				repeat (gap_cycles) @(posedge slow_clk);
			end
			8'h4: begin
				short_glitch(1'b0, key);
				repeat (gap_cycles) @(posedge slow_clk);
			end
			default: finish_failed($sformatf("%s has an action code that is not defined", name));
		endcase
		// Outputs are settled by the falling edge
		@(negedge slow_clk);
		check_outputs(name, exp_mode, exp_led, exp_digit);
	endtask

	initial begin
		void'($urandom(32'h48aa_5d90));
		rst_n = 1'b0;
		nav_raw = '0;
		note_raw_n = '1;
		n_steps = 0;
		stim_loaded = 1'b0;
		$readmemh("sim/piano_input.txt", stim_mem);
		while (n_steps < max_steps && !$isunknown(stim_mem[n_steps*fields])) begin
			n_steps++;
		end
		if (n_steps == 0) begin
			finish_failed("No steps could be read from sim/piano_input.txt");
		end
		stim_loaded = 1'b1;
		repeat (3) @(posedge slow_clk);
		rst_n <= 1'b1;
		for (int s = 0; s < n_steps; s++) begin
			run_step(s);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog sized from the number of steps
	initial begin
		wait (stim_loaded);
		repeat (n_steps * step_cycles + 3 + margin_cycles) @(posedge slow_clk);
		finish_failed("Timeout: the step list did not complete in the expected number of cycles");
	end

endmodule

`default_nettype wire

// File: source/piano_top.sv
`timescale 1ns/1ps
`default_nettype none

module piano_top
	import piano_pkg::*;
(
	input  wire logic      slow_clk,
	input  wire logic      rst_n,
	input  wire nav_keys_t nav_raw,
	input  wire note_vec_t note_raw_n,
	output mode_t          mode,
	output note_vec_t      led,
	output tub_frame_t     tub_frame
);

	key_events_t phys_events;
	note_vec_t   note_level;
	logic        setup_done;
	song_id_t    song_id;

	key_debouncer u_key_debouncer (
		.slow_clk   (slow_clk),
		.rst_n      (rst_n),
		.nav_raw    (nav_raw),
		.note_raw_n (note_raw_n),
		.events     (phys_events)
	);

	key_remap u_key_remap (
		.slow_clk   (slow_clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.phys       (phys_events),
		.note_level (note_level),
		.setup_done (setup_done)
	);

	mode_fsm u_mode_fsm (
		.slow_clk   (slow_clk),
		.rst_n      (rst_n),
		.nav_rise   (phys_events.rise.nav),
		.setup_done (setup_done),
		.mode       (mode)
	);

	song_selector u_song_selector (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.nav_rise (phys_events.rise.nav),
		.song_id  (song_id)
	);

	tub_text u_tub_text (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.song_id  (song_id),
		.frame    (tub_frame)
	);

	// Keys light the LEDs only on the playing pages
	assign led = (mode inside {mode_free, mode_play, mode_learn, mode_game}) ? note_level : '0;

endmodule

`default_nettype wire

// File: source/tub_text.sv
`timescale 1ns/1ps
`default_nettype none
`include "piano_settings.svh"

module tub_text
	import piano_pkg::*;
(
	input  wire logic     slow_clk,
	input  wire logic     rst_n,
	input  wire mode_t    mode,
	input  wire song_id_t song_id,
	output tub_frame_t    frame
);

	localparam tub_frame_t hello_frame = '{`GLYPH_H, `GLYPH_E, `GLYPH_L, `GLYPH_L,
		`GLYPH_O, `GLYPH_BLANK, `GLYPH_BLANK, `GLYPH_BLANK};

	tub_frame_t frame_d;
	tub_frame_t frame_q;

	// Songs are numbered from one on the display
	function automatic glyph_t song_glyph(input song_id_t id);
		case (id)
			3'd0:    return `GLYPH_1;
			3'd1:    return `GLYPH_2;
			3'd2:    return `GLYPH_3;
			3'd3:    return `GLYPH_4;
			3'd4:    return `GLYPH_5;
			3'd5:    return `GLYPH_6;
			3'd6:    return `GLYPH_7;
			default: return `GLYPH_8;
		endcase
	endfunction

	always_comb begin
		if (mode == mode_welcome) begin
			frame_d = hello_frame;
		end else if (mode == mode_choose) begin
			frame_d = '{`GLYPH_C, `GLYPH_H, `GLYPH_O, `GLYPH_O,
				`GLYPH_S, `GLYPH_E, `GLYPH_BLANK, `GLYPH_BLANK};
		end else if (mode inside {mode_song_play, mode_song_learn, mode_song_game,
				mode_play, mode_learn, mode_game}) begin
			frame_d = '{`GLYPH_S, `GLYPH_O, `GLYPH_N, `GLYPH_G,
				`GLYPH_BLANK, `GLYPH_BLANK, `GLYPH_0, song_glyph(song_id)};
		end else begin
			frame_d = {8{`GLYPH_BLANK}};
		end
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_q <= hello_frame;
		end else begin
			frame_q <= frame_d;
		end
	end

	assign frame = frame_q;

endmodule

`default_nettype wire

// File: source/song_selector.sv
`timescale 1ns/1ps
`default_nettype none
`include "piano_settings.svh"

module song_selector
	import piano_pkg::*;
(
	input  wire logic      slow_clk,
	input  wire logic      rst_n,
	input  wire mode_t     mode,
	input  wire nav_keys_t nav_rise,
	output song_id_t       song_id
);

	localparam int row_w = $clog2(`SONGS_PER_PAGE);
	localparam logic [row_w-1:0] last_row = row_w'(`SONGS_PER_PAGE - 1);

	logic             page_q;
	logic [row_w-1:0] row_q;
	logic             in_list;
	logic             nav_valid;

	assign in_list = mode inside {mode_song_play, mode_song_learn, mode_song_game};
	assign nav_valid = $onehot(nav_rise);

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			page_q <= 1'b0;
			row_q <= '0;
		end else if (in_list && nav_valid) begin
			// Rows wrap inside the current page
			if (nav_rise.up) begin
				row_q <= (row_q == '0) ? last_row : row_q - 1'b1;
			end else if (nav_rise.down) begin
				row_q <= (row_q == last_row) ? '0 : row_q + 1'b1;
			end else if (nav_rise.left || nav_rise.right) begin
				page_q <= ~page_q;
			end
		end
	end

	assign song_id = {page_q, row_q};

endmodule

`default_nettype wire

// File: source/mode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mode_fsm
	import piano_pkg::*;
(
	input  wire logic      slow_clk,
	input  wire logic      rst_n,
	input  wire nav_keys_t nav_rise,
	input  wire logic      setup_done,
	output mode_t          mode
);

	mode_t mode_q;
	mode_t mode_d;
	mode_t cursor_q;
	mode_t cursor_d;
	logic  nav_valid;

	// Up cycles free, setting, song_learn and song_play, ranking, song_game
	function automatic mode_t cursor_up(input mode_t cur);
		case (cur)
			mode_free:       return mode_setting;
			mode_setting:    return mode_song_learn;
			mode_song_learn: return mode_free;
			mode_song_play:  return mode_ranking;
			mode_ranking:    return mode_song_game;
			mode_song_game:  return mode_song_play;
			default:         return cur;
		endcase
	endfunction

	function automatic mode_t cursor_down(input mode_t cur);
		case (cur)
			mode_free:       return mode_song_learn;
			mode_song_learn: return mode_setting;
			mode_setting:    return mode_free;
			mode_song_play:  return mode_song_game;
			mode_song_game:  return mode_ranking;
			mode_ranking:    return mode_song_play;
			default:         return cur;
		endcase
	endfunction

	// Left and right both jump to the other column
	function automatic mode_t cursor_side(input mode_t cur);
		case (cur)
			mode_free:       return mode_song_play;
			mode_song_play:  return mode_free;
			mode_song_learn: return mode_song_game;
			mode_song_game:  return mode_song_learn;
			mode_setting:    return mode_ranking;
			mode_ranking:    return mode_setting;
			default:         return cur;
		endcase
	endfunction

	// Chords of several buttons are ignored
	assign nav_valid = $onehot(nav_rise);

	always_comb begin
		mode_d = mode_q;
		cursor_d = cursor_q;
		case (mode_q)
			mode_welcome: begin
				if (nav_valid && nav_rise.center) begin
					mode_d = mode_choose;
					cursor_d = mode_free;
				end
			end
			mode_choose: begin
				if (nav_valid) begin
					if (nav_rise.center) begin
						mode_d = cursor_q;
					end else if (nav_rise.esc) begin
						mode_d = mode_welcome;
					end else if (nav_rise.up) begin
						cursor_d = cursor_up(cursor_q);
					end else if (nav_rise.down) begin
						cursor_d = cursor_down(cursor_q);
					end else begin
						cursor_d = cursor_side(cursor_q);
					end
				end
			end
			mode_song_play: begin
				if (nav_valid && nav_rise.center) begin
					mode_d = mode_play;
				end else if (nav_valid && nav_rise.esc) begin
					mode_d = mode_choose;
				end
			end
			mode_song_learn: begin
				if (nav_valid && nav_rise.center) begin
					mode_d = mode_learn;
				end else if (nav_valid && nav_rise.esc) begin
					mode_d = mode_choose;
				end
			end
			mode_song_game: begin
				if (nav_valid && nav_rise.center) begin
					mode_d = mode_game;
				end else if (nav_valid && nav_rise.esc) begin
					mode_d = mode_choose;
				end
			end
			mode_play: begin
				if (nav_valid && nav_rise.esc) begin
					mode_d = mode_song_play;
				end
			end
			mode_learn: begin
				if (nav_valid && nav_rise.esc) begin
					mode_d = mode_song_learn;
				end
			end
			mode_game: begin
				if (nav_valid && nav_rise.esc) begin
					mode_d = mode_song_game;
				end
			end
			mode_free, mode_ranking: begin
				if (nav_valid && nav_rise.esc) begin
					mode_d = mode_choose;
				end
			end
			mode_setting: begin
				if (setup_done || (nav_valid && nav_rise.esc)) begin
					mode_d = mode_choose;
				end
			end
			default: mode_d = mode_welcome;
		endcase
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= mode_welcome;
			cursor_q <= mode_free;
		end else begin
			mode_q <= mode_d;
			cursor_q <= cursor_d;
		end
	end

	assign mode = mode_q;

endmodule

`default_nettype wire

// File: source/key_remap.sv
`timescale 1ns/1ps
`default_nettype none
`include "piano_settings.svh"

module key_remap
	import piano_pkg::*;
(
	input  wire logic        slow_clk,
	input  wire logic        rst_n,
	input  wire mode_t       mode,
	input  wire key_events_t phys,
	output note_vec_t        note_level,
	output logic             setup_done
);

	key_idx_t map_q [`NOTE_KEYS];
	key_idx_t teach_cnt_q;
	key_idx_t rise_idx;
	logic     teach_hit;

	// Logical key i follows physical button map_q[i]
	always_comb begin
		for (int i = 0; i < `NOTE_KEYS; i++) begin
			note_level[i] = phys.level.note[map_q[i]];
		end
	end

	// Index of the rising button, valid when only one rose
	always_comb begin
		rise_idx = '0;
		for (int i = 0; i < `NOTE_KEYS; i++) begin
			if (phys.rise.note[i]) begin
				rise_idx = key_idx_t'(i);
			end
		end
	end

	assign teach_hit = (mode == mode_setting) && $onehot(phys.rise.note);

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NOTE_KEYS; i++) begin
				map_q[i] <= key_idx_t'(i);
			end
			teach_cnt_q <= '0;
			setup_done <= 1'b0;
		end else begin
			setup_done <= 1'b0;
			if (mode != mode_setting) begin
				// Leaving setting early keeps what was taught so far
				teach_cnt_q <= '0;
			end else if (teach_hit) begin
				map_q[teach_cnt_q] <= rise_idx;
				teach_cnt_q <= teach_cnt_q + 1'b1;
				// Eighth store completes the map
				setup_done <= (teach_cnt_q == key_idx_t'(`NOTE_KEYS - 1));
			end
		end
	end

endmodule

`default_nettype wire

// File: source/key_debouncer.sv
`timescale 1ns/1ps
`default_nettype none
`include "piano_settings.svh"

module key_debouncer
	import piano_pkg::*;
(
	input  wire logic      slow_clk,
	input  wire logic      rst_n,
	input  wire nav_keys_t nav_raw,
	input  wire note_vec_t note_raw_n,
	output key_events_t    events
);

	localparam int n_keys = `NAV_KEYS + `NOTE_KEYS;
	localparam int cnt_w = $clog2(`KEY_STABLE_CYCLES + 1);

	logic [n_keys-1:0] raw;
	logic [n_keys-1:0] level_q;
	logic [n_keys-1:0] rise_q;
	logic [n_keys-1:0] fall_q;
	logic [cnt_w-1:0]  cnt_q [n_keys];

	// Note buttons pull low when pressed
	assign raw = {nav_raw, ~note_raw_n};

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			level_q <= '0;
			rise_q <= '0;
			fall_q <= '0;
			for (int i = 0; i < n_keys; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < n_keys; i++) begin
				rise_q[i] <= 1'b0;
				fall_q[i] <= 1'b0;
				if (raw[i] == level_q[i]) begin
					// Any agreement restarts the count
					cnt_q[i] <= '0;
				end else if (cnt_q[i] == cnt_w'(`KEY_STABLE_CYCLES - 1)) begin
					cnt_q[i] <= '0;
					level_q[i] <= raw[i];
					rise_q[i] <= raw[i];
					fall_q[i] <= ~raw[i];
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	assign events = '{level: level_q, rise: rise_q, fall: fall_q};

endmodule

`default_nettype wire

// File: source/piano_pkg.sv
`default_nettype none
`include "piano_settings.svh"

package piano_pkg;

	// Pages and modes of the keyboard menu
	typedef enum logic [3:0] {
		mode_welcome    = 4'd0,
		mode_choose     = 4'd1,
		mode_free       = 4'd2,
		mode_song_play  = 4'd3,
		mode_song_learn = 4'd4,
		mode_song_game  = 4'd5,
		mode_play       = 4'd6,
		mode_learn      = 4'd7,
		mode_game       = 4'd8,
		mode_setting    = 4'd9,
		mode_ranking    = 4'd10
	} mode_t;

	// One bit per note button
	typedef logic [`NOTE_KEYS-1:0] note_vec_t;

	// Physical note button number
	typedef logic [$clog2(`NOTE_KEYS)-1:0] key_idx_t;

	// Page in the top bit, row below
	typedef logic [2:0] song_id_t;

	typedef logic [7:0] glyph_t;

	// Position 7 is the leftmost digit
	typedef struct packed {
		glyph_t pos7;
		glyph_t pos6;
		glyph_t pos5;
		glyph_t pos4;
		glyph_t pos3;
		glyph_t pos2;
		glyph_t pos1;
		glyph_t pos0;
	} tub_frame_t;

	typedef struct packed {
		logic center;
		logic up;
		logic down;
		logic left;
		logic right;
		logic esc;
	} nav_keys_t;

	typedef struct packed {
		nav_keys_t nav;
		note_vec_t note;
	} key_bank_t;

	// Debounced levels with their edge pulses
	typedef struct packed {
		key_bank_t level;
		key_bank_t rise;
		key_bank_t fall;
	} key_events_t;

endpackage

`default_nettype wire

// File: source/piano_settings.svh
`ifndef PIANO_SETTINGS_SVH
`define PIANO_SETTINGS_SVH

// Cycles a raw button must disagree with its level before the level flips
`define KEY_STABLE_CYCLES 4

// Button counts
`define NOTE_KEYS 8
`define NAV_KEYS 6

// Two pages of songs
`define SONGS_PER_PAGE 4

// Segment codes, a to g in bits 7 to 1, dp in bit 0
`define GLYPH_H 8'h6e
`define GLYPH_E 8'h9e
`define GLYPH_L 8'h1c
`define GLYPH_O 8'hfc
`define GLYPH_C 8'h9c
`define GLYPH_S 8'hb6
`define GLYPH_N 8'h2a
`define GLYPH_G 8'hbc
`define GLYPH_0 8'hfc
`define GLYPH_1 8'h60
`define GLYPH_2 8'hda
`define GLYPH_3 8'hf2
`define GLYPH_4 8'h66
`define GLYPH_5 8'hb6
`define GLYPH_6 8'hbe
`define GLYPH_7 8'he0
`define GLYPH_8 8'hfe
`define GLYPH_BLANK 8'h00

`endif
